/* signed_remainder.f */
+incdir+src
src/signed_remainder_pkg.sv
src/operand_loader.sv
src/remainder_step.sv
src/division_sequencer.sv
src/signed_remainder.sv
bench/tb_clock_gen.sv
bench/signed_remainder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run into sim.log, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f signed_remainder.f \
    --top-module signed_remainder_tb -o signed_remainder_sim > build.log 2>&1 \
    && ./obj_dir/signed_remainder_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qx "All tests passed" sim.log && exit 0 || exit 1

/* bench/signed_remainder_tb.sv */
// testbench for the signed remainder unit
// directed and random divisions, reference model, concurrent checks, timeout

`timescale 1ns/100ps

`include "signed_remainder_cfg.svh"

module signed_remainder_tb;

    localparam int W = `SR_WORD_WIDTH;
    // accepting edge to the first sample that sees output_valid high
    localparam int LATENCY = `SR_WORD_WIDTH_LONG + 1;
    // about 400 divisions of up to 25 cycles each, plus margin
    localparam int TIMEOUT_CYCLES = 400 * 25 + 2000;

    logic         clock;
    logic         rst_n;
    logic         input_valid;
    logic         input_ready;
    logic [W-1:0] dividend;
    logic [W-1:0] divisor;
    logic         output_valid;
    logic         output_ready;
    logic [W-1:0] remainder;
    logic         divide_by_zero;
    // expected result of the division in flight
    logic [W-1:0] exp_remainder;
    logic         exp_divide_by_zero;
    logic [31:0]  rng_state;
    int           error_count;
    int           test_errors_start;
    int           failed_tests;
    int           divisions;
    int           cycle_count;

    tb_clock_gen u_clock_gen (.clock(clock), .rst_n(rst_n));

    signed_remainder u_dut (
        .clock(clock), .rst_n(rst_n), .input_valid(input_valid), .input_ready(input_ready),
        .dividend(dividend), .divisor(divisor), .output_valid(output_valid),
        .output_ready(output_ready), .remainder(remainder), .divide_by_zero(divide_by_zero)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // truncating division, a zero divisor leaves the dividend
    function automatic int reference_remainder(input int a, input int b);
        if (b == 0) return a;
        return a - (a / b) * b;
    endfunction

    task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
            $display("test %-12s ok", name);
        end else begin
            failed_tests = failed_tests + 1;
            $display("test %-12s failed, %0d check errors", name, error_count - test_errors_start);
        end
        test_errors_start = error_count;
    endtask

    // one full division, inputs change 2 ns after an edge
    task automatic divide(input int a, input int b, input int stall, input bit ready_early);
        input_valid = 1'b1;
        dividend = W'(a);
        divisor = W'(b);
        exp_remainder = W'(reference_remainder(a, b));
        exp_divide_by_zero = (b == 0);
        while (!input_ready) begin
            @(posedge clock);
            #2;
        end
        @(posedge clock);
        #2;
        input_valid = 1'b0;
        output_ready = ready_early;
        while (!output_valid) begin
            @(posedge clock);
            #2;
        end
        // back-pressure while the result waits
        repeat (stall) begin
            @(posedge clock);
            #2;
        end
        output_ready = 1'b1;
        @(posedge clock);
        #2;
        output_ready = 1'b0;
        divisions = divisions + 1;
    endtask

    assert property (@(posedge clock)
        $rose(rst_n) |-> input_ready && !output_valid && !divide_by_zero)
    else begin
        $display("CHECK FAILED reset state input_ready %h output_valid %h divide_by_zero %h",
                 $sampled(input_ready), $sampled(output_valid), $sampled(divide_by_zero));
        error_count = error_count + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        output_valid && output_ready |-> remainder == exp_remainder)
    else begin
        $display("CHECK FAILED remainder expected %h got %h",
                 $sampled(exp_remainder), $sampled(remainder));
        error_count = error_count + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        output_valid && output_ready |-> divide_by_zero == exp_divide_by_zero)
    else begin
        $display("CHECK FAILED divide_by_zero expected %h got %h",
                 $sampled(exp_divide_by_zero), $sampled(divide_by_zero));
        error_count = error_count + 1;
    end

    // result rises on the ninth edge after the accepting one
    assert property (@(posedge clock) disable iff (!rst_n)
        $rose(output_valid) |-> $past(input_valid && input_ready, LATENCY))
    else begin
        $display("output_valid rose without an input handshake %0d samples earlier", LATENCY);
        error_count = error_count + 1;
    end

    // no second operand pair while a division is in flight
    assert property (@(posedge clock) disable iff (!rst_n)
        input_valid && input_ready |=> !input_ready)
    else begin
        $display("input_ready stayed high after an input handshake");
        error_count = error_count + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        $rose(input_ready) |-> $past(output_valid && output_ready))
    else begin
        $display("input_ready rose without an output handshake in the cycle before");
        error_count = error_count + 1;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        output_valid && !output_ready |=>
            output_valid && $stable(remainder) && $stable(divide_by_zero))
    else begin
        $display("result changed or was dropped while waiting for output_ready");
        error_count = error_count + 1;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int a;
        int b;
        int edge_a [12];
        int edge_b [12];
        input_valid = 1'b0;
        dividend = '0;
        divisor = '0;
        output_ready = 1'b0;
        exp_remainder = '0;
        exp_divide_by_zero = 1'b0;
        rng_state = 32'h3014_0a60;
        error_count = 0;
        test_errors_start = 0;
        failed_tests = 0;
        divisions = 0;
        cycle_count = 0;
        while (rst_n !== 1'b1) @(posedge clock);
        @(posedge clock);
        #2;
        end_test("reset_state");
        // 22 and 7, then 7 and 22, in all four sign combinations
        for (int s = 0; s < 8; s++) begin
            a = (s < 4) ? 22 : 7;
            b = (s < 4) ? 7 : 22;
            divide(s[0] ? -a : a, s[1] ? -b : b, 1, 1'b0);
        end
        end_test("sign_table");
        divide(45, 0, 0, 1'b0);
        divide(-100, 0, 2, 1'b0);
        divide(-128, 0, 0, 1'b0);
        divide(0, 0, 1, 1'b0);
        // non-zero divisor must clear the flag again
        divide(45, 3, 0, 1'b0);
        end_test("divide_zero");
        edge_a = '{-128, -128, -128, -128, 127, 127, 127, -1, 0, -128, 1, -127};
        edge_b = '{-1, 1, -128, 127, -128, 127, 1, -128, 5, 2, -1, -128};
        foreach (edge_a[i]) divide(edge_a[i], edge_b[i], i % 3, 1'b0);
        end_test("extremes");
        // output_ready already high, so the result leaves on its first cycle
        divide(100, 9, 0, 1'b1);
        divide(-77, 6, 0, 1'b1);
        divide(-128, -3, 0, 1'b1);
        end_test("latency");
        for (int i = 0; i < 300; i++) begin
            rng_state = next_random(rng_state);
            divide(int'($signed(rng_state[7:0])), int'($signed(rng_state[15:8])),
                   rng_state[23:16] % 5, 1'b0);
        end
        end_test("random");
        $display("tests 6, failed tests %0d, divisions %0d, check errors %0d",
                 failed_tests, divisions, error_count);
        if (error_count == 0 && failed_tests == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
// clock and reset source for the testbench
// 20 ns clock, rst_n low for the first 8 cycles

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        rst_n = 1'b1;
    end

endmodule

/* src/signed_remainder.sv */
// signed_remainder: iterative truncating signed remainder
// sequencer, operand loader and step unit wired together

`timescale 1ns/100ps

`include "signed_remainder_cfg.svh"

module signed_remainder
    import signed_remainder_pkg::*;
(
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        input_valid,
    output logic                        input_ready,
    input  logic [`SR_WORD_WIDTH-1:0]   dividend,
    input  logic [`SR_WORD_WIDTH-1:0]   divisor,
    output logic                        output_valid,
    input  logic                        output_ready,
    output logic [`SR_WORD_WIDTH-1:0]   remainder,
    output logic                        divide_by_zero
);

    // sequencer controls
    logic load_inputs;
    logic step_en;
    logic first_step;

    // operand state toward the step unit
    logic [`SR_WORD_WIDTH_LONG-1:0] dividend_long;
    logic [`SR_WORD_WIDTH_LONG-1:0] divisor_shift;
    logic [`SR_WORD_WIDTH_LONG-1:0] remainder_increment;
    logic                           dividend_sign;
    logic                           increment_valid;
    step_op_e                       step_op;

    division_sequencer u_sequencer (
        .clock        (clock),
        .rst_n        (rst_n),
        .input_valid  (input_valid),
        .output_ready (output_ready),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .load_inputs  (load_inputs),
        .step_en      (step_en),
        .first_step   (first_step)
    );

    // divisor sign is only used inside the loader
    operand_loader u_loader (
        .clock               (clock),
        .rst_n               (rst_n),
        .dividend            (dividend),
        .divisor             (divisor),
        .load_inputs         (load_inputs),
        .step_en             (step_en),
        .dividend_long       (dividend_long),
        .dividend_sign       (dividend_sign),
        .divisor_sign        (),
        .divisor_shift       (divisor_shift),
        .remainder_increment (remainder_increment),
        .increment_valid     (increment_valid),
        .step_op             (step_op)
    );

    remainder_step u_step (
        .clock               (clock),
        .rst_n               (rst_n),
        .load_inputs         (load_inputs),
        .step_en             (step_en),
        .first_step          (first_step),
        .dividend_long       (dividend_long),
        .dividend_sign       (dividend_sign),
        .divisor_shift       (divisor_shift),
        .remainder_increment (remainder_increment),
        .increment_valid     (increment_valid),
        .step_op             (step_op),
        .remainder           (remainder),
        .divide_by_zero      (divide_by_zero)
    );

endmodule

/* src/division_sequencer.sv */
// division_sequencer: load/calc/done FSM, step counter,
// and the input and output ready/valid handshakes

`timescale 1ns/100ps

`include "signed_remainder_cfg.svh"

module division_sequencer
    import signed_remainder_pkg::*;
(
    input  logic clock,
    input  logic rst_n,
    input  logic input_valid,
    input  logic output_ready,
    output logic input_ready,
    output logic output_valid,
    output logic load_inputs,
    output logic step_en,
    output logic first_step
);

    localparam logic [`SR_STEPS_WIDTH-1:0] STEPS_INITIAL =
        `SR_STEPS_WIDTH'(`SR_STEPS_INITIAL);

    seq_state_e                  state;
    seq_state_e                  state_next;
    logic [`SR_STEPS_WIDTH-1:0]  step_count;
    logic                        last_step;
    logic                        read_outputs;

    // ready and valid come from state only
    assign input_ready  = (state == STATE_LOAD);
    assign output_valid = (state == STATE_DONE);

    // handshake and step events
    assign load_inputs  = input_ready && input_valid;
    assign read_outputs = output_valid && output_ready;
    assign step_en      = (state == STATE_CALC);
    assign first_step   = step_en && (step_count == STEPS_INITIAL);
    assign last_step    = step_en && (step_count == '0);

    always_comb begin
        state_next = state;
        case (state)
            STATE_LOAD: if (load_inputs)  state_next = STATE_CALC;
            STATE_CALC: if (last_step)    state_next = STATE_DONE;
            STATE_DONE: if (read_outputs) state_next = STATE_LOAD;
            default:                      state_next = STATE_LOAD;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= STATE_LOAD;
        end else begin
            state <= state_next;
        end
    end

    // one count per calc cycle, long-width steps in total
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            step_count <= STEPS_INITIAL;
        end else if (load_inputs) begin
            step_count <= STEPS_INITIAL;
        end else if (step_en && !last_step) begin
            step_count <= step_count - 1'b1;
        end
    end

    // calc phase ends exactly long-width steps after the load
    assert property (@(posedge clock) disable iff (!rst_n)
        last_step |-> $past(load_inputs, `SR_WORD_WIDTH_LONG));

endmodule

/* src/remainder_step.sv */
// remainder_step: one add/subtract step per cycle on the long remainder,
// step acceptance, and the divide_by_zero flag

`timescale 1ns/100ps

`include "signed_remainder_cfg.svh"

module remainder_step
    import signed_remainder_pkg::*;
(
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            load_inputs,
    input  logic                            step_en,
    input  logic                            first_step,
    input  logic [`SR_WORD_WIDTH_LONG-1:0]  dividend_long,
    input  logic                            dividend_sign,
    input  logic [`SR_WORD_WIDTH_LONG-1:0]  divisor_shift,
    input  logic [`SR_WORD_WIDTH_LONG-1:0]  remainder_increment,
    input  logic                            increment_valid,
    input  step_op_e                        step_op,
    output logic [`SR_WORD_WIDTH-1:0]       remainder,
    output logic                            divide_by_zero
);

    localparam int LW = `SR_WORD_WIDTH_LONG;

    logic [LW-1:0] remainder_long;
    logic [LW-1:0] candidate;
    logic          operand_sign;
    logic          candidate_overflow;
    logic          step_accept;
    logic          divisor_is_zero;

    // single combinational add or subtract
    assign candidate = (step_op == OP_SUB) ? (remainder_long - remainder_increment)
                                           : (remainder_long + remainder_increment);

    // sign of the second operand as the adder sees it
    assign operand_sign = (step_op == OP_SUB) ? ~remainder_increment[LW-1]
                                              : remainder_increment[LW-1];

    // two's complement overflow: like signs in, different sign out
    assign candidate_overflow = (remainder_long[LW-1] == operand_sign) &&
                                (candidate[LW-1] != remainder_long[LW-1]);

    // keep the step only if it lands on zero or stays on the dividend's side
    assign step_accept = increment_valid &&
                         ((candidate == '0) ||
                          ((candidate[LW-1] == dividend_sign) && !candidate_overflow));

    // remainder starts as the dividend and shrinks toward zero
    always_ff @(posedge clock) begin
        if (load_inputs) begin
            remainder_long <= dividend_long;
        end else if (step_en && step_accept) begin
            remainder_long <= candidate;
        end
    end

    // the extra bit is only needed internally
    assign remainder = remainder_long[`SR_WORD_WIDTH-1:0];

    // undo the load-time shift to recover the original divisor
    assign divisor_is_zero =
        ({divisor_shift[`SR_WORD_WIDTH-1:0], remainder_increment[LW-1]} == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            divide_by_zero <= 1'b0;
        end else if (first_step) begin
            divide_by_zero <= divisor_is_zero;
        end
    end

    // never crosses zero during the calc phase
    assert property (@(posedge clock) disable iff (!rst_n)
        step_en |-> (remainder_long == '0) || (remainder_long[LW-1] == dividend_sign));

endmodule

/* src/operand_loader.sv */
// operand_loader: extends dividend and divisor, keeps their initial signs,
// and shifts the divisor one bit per step into the remainder increment

`timescale 1ns/100ps

`include "signed_remainder_cfg.svh"

module operand_loader
    import signed_remainder_pkg::*;
(
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic [`SR_WORD_WIDTH-1:0]       dividend,
    input  logic [`SR_WORD_WIDTH-1:0]       divisor,
    input  logic                            load_inputs,
    input  logic                            step_en,
    output logic [`SR_WORD_WIDTH_LONG-1:0]  dividend_long,
    output logic                            dividend_sign,
    output logic                            divisor_sign,
    output logic [`SR_WORD_WIDTH_LONG-1:0]  divisor_shift,
    output logic [`SR_WORD_WIDTH_LONG-1:0]  remainder_increment,
    output logic                            increment_valid,
    output step_op_e                        step_op
);

    localparam int LW = `SR_WORD_WIDTH_LONG;

    logic [LW-1:0] divisor_long;
    logic          divisor_all_sign;

    // sign extension to the long width
    assign dividend_long = {dividend[`SR_WORD_WIDTH-1], dividend};
    assign divisor_long  = {divisor[`SR_WORD_WIDTH-1], divisor};

    // initial signs, taken once per division
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dividend_sign <= 1'b0;
            divisor_sign  <= 1'b0;
        end else if (load_inputs) begin
            dividend_sign <= dividend_long[LW-1];
            divisor_sign  <= divisor_long[LW-1];
        end
    end

    // divisor lsb moves into the increment msb on every step
    // the load already does the first shift
    always_ff @(posedge clock) begin
        if (load_inputs) begin
            divisor_shift       <= {divisor_long[LW-1], divisor_long[LW-1:1]};
            remainder_increment <= {divisor_long[0], {(LW-1){1'b0}}};
        end else if (step_en) begin
            // arithmetic shift done by hand, sign bit replicated
            divisor_shift       <= {divisor_shift[LW-1], divisor_shift[LW-1:1]};
            remainder_increment <= {divisor_shift[0], remainder_increment[LW-1:1]};
        end
    end

    // non-sign bits left in the divisor mean the increment is incomplete
    assign divisor_all_sign = divisor_sign ? (divisor_shift == '1) : (divisor_shift == '0);

    // increment is a usable multiple only once its sign agrees too
    assign increment_valid = divisor_all_sign &&
                             (remainder_increment[LW-1] == divisor_sign);

    // same signs: subtract to head toward zero, otherwise add
    assign step_op = (divisor_sign == dividend_sign) ? OP_SUB : OP_ADD;

    // signs must hold for the whole calc phase
    assert property (@(posedge clock) disable iff (!rst_n)
        step_en |=> $stable(dividend_sign) && $stable(divisor_sign));

endmodule

/* src/signed_remainder_pkg.sv */
// shared types for the signed remainder unit
// sequencer state encoding and add/subtract selection

package signed_remainder_pkg;

    // load -> calc -> done -> load
    // 2'b01 is never reached
    typedef enum logic [1:0] {
        STATE_LOAD = 2'b00,
        STATE_CALC = 2'b10,
        STATE_DONE = 2'b11
    } seq_state_e;

    // how the increment is applied to the remainder
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } step_op_e;

endpackage

/* src/signed_remainder_cfg.svh */
// word widths and step count for the signed remainder unit
// the internal data path is one bit wider than the word

`ifndef SIGNED_REMAINDER_CFG_SVH
`define SIGNED_REMAINDER_CFG_SVH

// operand and remainder width
`define SR_WORD_WIDTH 8

// extra bit so the most negative dividend can reach zero
`define SR_WORD_WIDTH_LONG (`SR_WORD_WIDTH + 1)

// step counter, wide enough to count down from the long width minus one
`define SR_STEPS_WIDTH 4

// counter value at the first calc step
`define SR_STEPS_INITIAL (`SR_WORD_WIDTH_LONG - 1)

`endif
